/* design/pet_pkg.sv */
//------------------------------
// pet package
// shared types, state encodings, defaults and sprite codes
//------------------------------
`default_nettype none

package pet_pkg;

	// widths that carry a meaning
	typedef logic [3:0] stat_t;
	typedef logic [7:0] sprite_t;
	typedef logic [7:0] key_t;
	// phase 1..8, value 8 held as 0
	typedef logic [2:0] phase_t;

	typedef struct packed {
		stat_t health;
		stat_t fullness;
		stat_t affection;
	} pet_stats_t;

	typedef enum logic [3:0] {
		st_start,
		st_check,
		st_idle,
		st_feed,
		st_feed_reward,
		st_pet,
		st_pet_reward,
		st_upset,
		st_dead
	} pet_state_t;

	typedef enum logic {
		mood_happy,
		mood_sad
	} mood_t;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_restore,
		cmd_decay,
		cmd_hurt,
		cmd_feed,
		cmd_pet
	} stat_cmd_t;

	// what the display side needs to know
	typedef struct packed {
		pet_state_t state;
		mood_t      mood;
		phase_t     phase;
	} pet_view_t;

	// ------------------------------
	// defaults for the top level parameters
	localparam int    DEF_DWELL_FRAMES  = 21;
	localparam stat_t DEF_START_LEVEL   = 4'd5;
	localparam stat_t DEF_CONTENT_LEVEL = 4'd5;
	localparam stat_t DEF_FULL_LIMIT    = 4'd9;
	localparam key_t  DEF_PET_KEY       = 8'h1a;
	localparam key_t  DEF_START_KEY     = 8'h16;

	// first and last idle phase
	localparam phase_t PHASE_FIRST = 3'd1;
	localparam phase_t PHASE_LAST  = 3'd0;

	// ------------------------------
	// sprite codes
	localparam sprite_t SPR_NEUTRAL    = 8'h00;
	localparam sprite_t SPR_SAD        = 8'h01;
	localparam sprite_t SPR_HAPPY_BASE = 8'ha0;
	localparam sprite_t SPR_SAD_BASE   = 8'hb0;
	localparam sprite_t SPR_FED        = 8'hc1;
	localparam sprite_t SPR_PETTED     = 8'hd1;

endpackage

`default_nettype wire

/* design/frame_timer.sv */
//------------------------------
// frame timer
// counts frames since the last clear, flags the last frame of a dwell
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
	parameter int DWELL_FRAMES = pet_pkg::DEF_DWELL_FRAMES
) (
	input  logic frame_clk,
	input  logic reset,
	input  logic clear,
	output logic expired
);

	// at least one bit even for a one-frame dwell
	localparam int CNT_W = (DWELL_FRAMES > 1) ? $clog2(DWELL_FRAMES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DWELL_FRAMES - 1);

	logic [CNT_W-1:0] count;
	logic             last;

	assign last = (count == CNT_LAST);

	// last frame of the dwell
	assign expired = last;

	// wraps after the last frame so a parked state (dead) keeps it in range
	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset)
			count <= '0;
		else if (clear || last)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	// count stays inside one dwell window
	a_count_range: assert property (@(posedge frame_clk) disable iff (reset)
		int'(count) <= DWELL_FRAMES - 1);

endmodule

`default_nettype wire

/* design/stat_keeper.sv */
//------------------------------
// stat keeper
// health, fullness and affection, saturating 0..15
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module stat_keeper #(
	parameter pet_pkg::stat_t START_LEVEL = pet_pkg::DEF_START_LEVEL
) (
	input  logic                frame_clk,
	input  logic                reset,
	input  pet_pkg::stat_cmd_t  cmd,
	output pet_pkg::pet_stats_t stats
);

	import pet_pkg::*;

	// up by one, stuck at 15
	function automatic stat_t sat_inc(input stat_t s);
		return (s == '1) ? s : stat_t'(s + 4'd1);
	endfunction

	// down by one, stuck at 0
	function automatic stat_t sat_dec(input stat_t s);
		return (s == '0) ? s : stat_t'(s - 4'd1);
	endfunction

	// ------------------------------
	// command applied at the end of its single cycle
	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			stats.health    <= START_LEVEL;
			stats.fullness  <= START_LEVEL;
			stats.affection <= START_LEVEL;
		end else begin
			case (cmd)
				cmd_restore: begin
					stats.health    <= START_LEVEL;
					stats.fullness  <= START_LEVEL;
					stats.affection <= START_LEVEL;
				end
				// end of an idle round
				cmd_decay: begin
					stats.health   <= sat_dec(stats.health);
					stats.fullness <= sat_dec(stats.fullness);
				end
				cmd_hurt: stats.health <= sat_dec(stats.health);
				cmd_feed: begin
					stats.health   <= sat_inc(stats.health);
					stats.fullness <= sat_inc(stats.fullness);
				end
				cmd_pet: begin
					stats.health    <= sat_inc(stats.health);
					stats.affection <= sat_inc(stats.affection);
				end
				default: ;
			endcase
		end
	end

	// stats only move on a real command
	a_stats_hold: assert property (@(posedge frame_clk) disable iff (reset)
		(cmd == cmd_none) |=> $stable(stats));

endmodule

`default_nettype wire

/* design/pet_fsm.sv */
//------------------------------
// pet mood machine
// idle phases, feed/pet/upset episodes, death and restart
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pet_fsm #(
	parameter pet_pkg::stat_t CONTENT_LEVEL = pet_pkg::DEF_CONTENT_LEVEL,
	parameter pet_pkg::stat_t FULL_LIMIT    = pet_pkg::DEF_FULL_LIMIT,
	parameter pet_pkg::key_t  PET_KEY       = pet_pkg::DEF_PET_KEY,
	parameter pet_pkg::key_t  START_KEY     = pet_pkg::DEF_START_KEY
) (
	input  logic                frame_clk,
	input  logic                reset,
	input  logic                eaten,
	input  logic                hurt,
	input  pet_pkg::key_t       key,
	input  pet_pkg::pet_stats_t stats,
	input  logic                expired,
	output logic                timer_clear,
	output pet_pkg::stat_cmd_t  cmd,
	output pet_pkg::pet_view_t  view
);

	import pet_pkg::*;

	pet_state_t state_q, state_d;
	mood_t      mood_q, mood_d;
	phase_t     phase_q, phase_d;
	stat_cmd_t  cmd_q, cmd_d;
	// a transition is taken this cycle (re-entry included)
	logic       advance;

	// key decode
	logic       pet_hit, start_hit;
	// interrupt request and where it leads
	logic       irq;
	pet_state_t irq_state;
	// stat checks
	logic       all_content, any_zero;

	assign pet_hit   = (key == PET_KEY);
	assign start_hit = (key == START_KEY);

	// priority eaten > pet key > hurt
	assign irq = eaten | pet_hit | hurt;
	assign irq_state = eaten ? st_feed : (pet_hit ? st_pet : st_upset);

	assign all_content = (stats.health >= CONTENT_LEVEL) &&
		(stats.fullness >= CONTENT_LEVEL) && (stats.affection >= CONTENT_LEVEL);
	assign any_zero = (stats.health == '0) || (stats.fullness == '0) ||
		(stats.affection == '0);

	// command carried into the first cycle of a state
	function automatic stat_cmd_t entry_cmd(input pet_state_t st, input phase_t ph);
		case (st)
			st_start:       return cmd_restore;
			st_idle:        return (ph == PHASE_LAST) ? cmd_decay : cmd_none;
			st_upset:       return cmd_hurt;
			st_feed_reward: return cmd_feed;
			st_pet_reward:  return cmd_pet;
			default:        return cmd_none;
		endcase
	endfunction

	// ------------------------------
	// next state
	always_comb begin
		state_d = state_q;
		mood_d  = mood_q;
		phase_d = phase_q;
		advance = 1'b0;
		case (state_q)
			st_start: begin
				state_d = st_check;
				advance = 1'b1;
			end
			// one cycle look at the stats
			st_check: begin
				advance = 1'b1;
				state_d = st_idle;
				phase_d = PHASE_FIRST;
				if (all_content)
					mood_d = mood_happy;
				else if (any_zero)
					state_d = st_dead;
				else
					mood_d = mood_sad;
			end
			st_idle: begin
				if (irq) begin
					state_d = irq_state;
					advance = 1'b1;
				end else if (expired) begin
					advance = 1'b1;
					// phase 8 done, back to check
					if (phase_q == PHASE_LAST)
						state_d = st_check;
					else
						phase_d = phase_t'(phase_q + 3'd1);
				end
			end
			// episodes that ignore interrupts
			st_feed: begin
				if (expired) begin
					advance = 1'b1;
					state_d = (stats.fullness <= FULL_LIMIT) ? st_feed_reward : st_upset;
				end
			end
			st_pet: begin
				if (expired) begin
					advance = 1'b1;
					state_d = (stats.affection <= FULL_LIMIT) ? st_pet_reward : st_upset;
				end
			end
			st_pet_reward: begin
				if (expired) begin
					advance = 1'b1;
					state_d = st_check;
				end
			end
			// these two take interrupts, hurt re-enters upset
			st_feed_reward, st_upset: begin
				if (irq) begin
					state_d = irq_state;
					advance = 1'b1;
				end else if (expired) begin
					state_d = st_check;
					advance = 1'b1;
				end
			end
			st_dead: begin
				if (start_hit) begin
					state_d = st_start;
					advance = 1'b1;
				end
			end
			default: begin
				state_d = st_start;
				advance = 1'b1;
			end
		endcase
		cmd_d = advance ? entry_cmd(state_d, phase_d) : cmd_none;
	end

	// ------------------------------
	// state, mood, phase and command registers
	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			state_q <= st_start;
			mood_q  <= mood_happy;
			phase_q <= PHASE_FIRST;
			cmd_q   <= cmd_none;
		end else begin
			state_q <= state_d;
			mood_q  <= mood_d;
			phase_q <= phase_d;
			cmd_q   <= cmd_d;
		end
	end

	assign timer_clear = advance;
	assign cmd         = cmd_q;
	assign view.state  = state_q;
	assign view.mood   = mood_q;
	assign view.phase  = phase_q;

	// every state or phase step restarted the dwell timer
	a_clear_on_change: assert property (@(posedge frame_clk) disable iff (reset)
		(view.state != $past(view.state) || view.phase != $past(view.phase))
		|-> $past(timer_clear));

endmodule

`default_nettype wire

/* design/sprite_select.sv */
//------------------------------
// sprite select
// registered sprite code, one frame behind the view
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module sprite_select (
	input  logic               frame_clk,
	input  logic               reset,
	input  pet_pkg::pet_view_t view,
	output pet_pkg::sprite_t   sprite
);

	import pet_pkg::*;

	sprite_t sprite_d;

	// idle frames, base + phase number 1..8
	function automatic sprite_t idle_code(input mood_t m, input phase_t ph);
		sprite_t num;
		num = (ph == PHASE_LAST) ? 8'd8 : {5'd0, ph};
		return ((m == mood_happy) ? SPR_HAPPY_BASE : SPR_SAD_BASE) + num;
	endfunction

	// sprite table
	always_comb begin
		case (view.state)
			st_idle:           sprite_d = idle_code(view.mood, view.phase);
			st_upset, st_dead: sprite_d = SPR_SAD;
			st_feed_reward:    sprite_d = SPR_FED;
			st_pet_reward:     sprite_d = SPR_PETTED;
			// start, check, feed, pet
			default:           sprite_d = SPR_NEUTRAL;
		endcase
	end

	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset)
			sprite <= SPR_NEUTRAL;
		else
			sprite <= sprite_d;
	end

endmodule

`default_nettype wire

/* design/pet_game.sv */
//------------------------------
// virtual pet top level
// timer, mood machine, stats and sprite output
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pet_game #(
	parameter int             DWELL_FRAMES  = pet_pkg::DEF_DWELL_FRAMES,
	parameter pet_pkg::stat_t START_LEVEL   = pet_pkg::DEF_START_LEVEL,
	parameter pet_pkg::stat_t CONTENT_LEVEL = pet_pkg::DEF_CONTENT_LEVEL,
	parameter pet_pkg::stat_t FULL_LIMIT    = pet_pkg::DEF_FULL_LIMIT,
	parameter pet_pkg::key_t  PET_KEY       = pet_pkg::DEF_PET_KEY,
	parameter pet_pkg::key_t  START_KEY     = pet_pkg::DEF_START_KEY
) (
	input  logic                frame_clk,
	input  logic                reset,
	input  logic                eaten,
	input  logic                hurt,
	input  pet_pkg::key_t       key,
	output pet_pkg::sprite_t    sprite,
	output pet_pkg::pet_stats_t stats
);

	import pet_pkg::*;

	logic      timer_clear;
	logic      expired;
	stat_cmd_t cmd;
	pet_view_t view;

	// dwell per state or phase
	frame_timer #(
		.DWELL_FRAMES(DWELL_FRAMES)
	) u_timer (
		.frame_clk(frame_clk),
		.reset    (reset),
		.clear    (timer_clear),
		.expired  (expired)
	);

	pet_fsm #(
		.CONTENT_LEVEL(CONTENT_LEVEL),
		.FULL_LIMIT   (FULL_LIMIT),
		.PET_KEY      (PET_KEY),
		.START_KEY    (START_KEY)
	) u_fsm (
		.frame_clk  (frame_clk),
		.reset      (reset),
		.eaten      (eaten),
		.hurt       (hurt),
		.key        (key),
		.stats      (stats),
		.expired    (expired),
		.timer_clear(timer_clear),
		.cmd        (cmd),
		.view       (view)
	);

	// stats feed back into the fsm and out
	stat_keeper #(
		.START_LEVEL(START_LEVEL)
	) u_stats (
		.frame_clk(frame_clk),
		.reset    (reset),
		.cmd      (cmd),
		.stats    (stats)
	);

	sprite_select u_sprite (
		.frame_clk(frame_clk),
		.reset    (reset),
		.view     (view),
		.sprite   (sprite)
	);

endmodule

`default_nettype wire

/* verif/pet_model.svh */
//------------------------------
// pet reference model
// one frame step of the whole pet, gives the expected sprite and stats
//------------------------------
`ifndef PET_MODEL_SVH
`define PET_MODEL_SVH

// full model state, phase kept as 1..8
typedef struct packed {
	pet_state_t state;
	mood_t      mood;
	int         phase;
	int         count;
	stat_cmd_t  cmd;
	pet_stats_t stats;
	sprite_t    sprite;
} model_t;

function automatic model_t model_reset();
	model_t m;
	m.state           = st_start;
	m.mood            = mood_happy;
	m.phase           = 1;
	m.count           = 0;
	m.cmd             = cmd_none;
	m.stats.health    = stat_t'(START_LEVEL);
	m.stats.fullness  = stat_t'(START_LEVEL);
	m.stats.affection = stat_t'(START_LEVEL);
	m.sprite          = SPR_NEUTRAL;
	return m;
endfunction

// keep a level inside 0..15
function automatic stat_t clamp_stat(input int v);
	if (v < 0)
		return 4'd0;
	if (v > 15)
		return 4'd15;
	return stat_t'(v);
endfunction

// what the display shows for a given view
function automatic sprite_t expected_sprite(input pet_state_t st, input mood_t md, input int ph);
	case (st)
		st_idle: begin
			if (md == mood_happy)
				return sprite_t'(int'(SPR_HAPPY_BASE) + ph);
			return sprite_t'(int'(SPR_SAD_BASE) + ph);
		end
		st_upset, st_dead: return SPR_SAD;
		st_feed_reward:    return SPR_FED;
		st_pet_reward:     return SPR_PETTED;
		default:           return SPR_NEUTRAL;
	endcase
endfunction

// next frame from this frame's state and inputs
function automatic model_t model_step(input model_t m, input logic ev_eaten,
	input logic ev_hurt, input key_t ev_key);
	model_t     n;
	logic       expired;
	logic       moved;
	logic       pet_press;
	logic       irq;
	pet_state_t irq_to;
	int         h;
	int         f;
	int         a;
	n         = m;
	moved     = 1'b0;
	expired   = (m.count == DWELL - 1);
	pet_press = (ev_key == PET_KEY);
	irq       = ev_eaten || pet_press || ev_hurt;
	// eaten first, then the pet key, then hurt
	if (ev_eaten)
		irq_to = st_feed;
	else if (pet_press)
		irq_to = st_pet;
	else
		irq_to = st_upset;

	case (m.state)
		st_start: begin
			n.state = st_check;
			moved   = 1'b1;
		end
		st_check: begin
			moved   = 1'b1;
			n.phase = 1;
			if (int'(m.stats.health) >= CONTENT_LEVEL && int'(m.stats.fullness) >= CONTENT_LEVEL
				&& int'(m.stats.affection) >= CONTENT_LEVEL) begin
				n.state = st_idle;
				n.mood  = mood_happy;
			end else if (m.stats.health == 0 || m.stats.fullness == 0
				|| m.stats.affection == 0) begin
				n.state = st_dead;
			end else begin
				n.state = st_idle;
				n.mood  = mood_sad;
			end
		end
		st_idle: begin
			if (irq) begin
				n.state = irq_to;
				moved   = 1'b1;
			end else if (expired) begin
				moved = 1'b1;
				if (m.phase == 8)
					n.state = st_check;
				else
					n.phase = m.phase + 1;
			end
		end
		st_feed: begin
			if (expired) begin
				moved   = 1'b1;
				n.state = (int'(m.stats.fullness) <= FULL_LIMIT) ? st_feed_reward : st_upset;
			end
		end
		st_pet: begin
			if (expired) begin
				moved   = 1'b1;
				n.state = (int'(m.stats.affection) <= FULL_LIMIT) ? st_pet_reward : st_upset;
			end
		end
		st_pet_reward: begin
			if (expired) begin
				moved   = 1'b1;
				n.state = st_check;
			end
		end
		st_feed_reward, st_upset: begin
			if (irq) begin
				n.state = irq_to;
				moved   = 1'b1;
			end else if (expired) begin
				n.state = st_check;
				moved   = 1'b1;
			end
		end
		st_dead: begin
			if (ev_key == START_KEY) begin
				n.state = st_start;
				moved   = 1'b1;
			end
		end
		default: ;
	endcase

	// dwell restarts on a move and wraps on its own
	n.count = (moved || expired) ? 0 : m.count + 1;

	// command issued last frame lands now
	h = int'(m.stats.health);
	f = int'(m.stats.fullness);
	a = int'(m.stats.affection);
	case (m.cmd)
		cmd_restore: begin
			h = START_LEVEL;
			f = START_LEVEL;
			a = START_LEVEL;
		end
		cmd_decay: begin
			h = h - 1;
			f = f - 1;
		end
		cmd_hurt: h = h - 1;
		cmd_feed: begin
			h = h + 1;
			f = f + 1;
		end
		cmd_pet: begin
			h = h + 1;
			a = a + 1;
		end
		default: ;
	endcase
	n.stats.health    = clamp_stat(h);
	n.stats.fullness  = clamp_stat(f);
	n.stats.affection = clamp_stat(a);

	// entry command rides with the new state
	n.cmd = cmd_none;
	if (moved) begin
		case (n.state)
			st_start:       n.cmd = cmd_restore;
			st_idle:        n.cmd = (n.phase == 8) ? cmd_decay : cmd_none;
			st_upset:       n.cmd = cmd_hurt;
			st_feed_reward: n.cmd = cmd_feed;
			st_pet_reward:  n.cmd = cmd_pet;
			default:        n.cmd = cmd_none;
		endcase
	end

	n.sprite = expected_sprite(m.state, m.mood, m.phase);
	return n;
endfunction

`endif

/* verif/pet_game_tb.sv */
//------------------------------
// pet game testbench
// directed episodes and a random run against a frame exact model
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module pet_game_tb;

	import pet_pkg::*;

	// values the pet runs with here
	localparam int   DWELL         = 4;
	localparam int   START_LEVEL   = 5;
	localparam int   CONTENT_LEVEL = 5;
	localparam int   FULL_LIMIT    = 9;
	localparam key_t PET_KEY       = 8'h1a;
	localparam key_t START_KEY     = 8'h16;
	localparam int   WAIT_LIMIT    = 64;

	logic       frame_clk;
	logic       reset;
	logic       eaten;
	logic       hurt;
	key_t       key;
	sprite_t    sprite;
	pet_stats_t stats;

	// directed errors and model mismatches counted apart
	int          errors;
	int          mismatches = 0;
	int          tests_run;
	int          tests_failed;
	int          err_mark;
	logic [31:0] rng;

	`include "pet_model.svh"

	model_t model;

	pet_game #(
		.DWELL_FRAMES(DWELL)
	) dut0 (
		.frame_clk(frame_clk),
		.reset    (reset),
		.eaten    (eaten),
		.hurt     (hurt),
		.key      (key),
		.sprite   (sprite),
		.stats    (stats)
	);

	// 20 ns frame
	initial begin
		frame_clk = 1'b0;
		forever #10 frame_clk = ~frame_clk;
	end

	// ------------------------------
	// compare and step the model on the same edge
	always @(posedge frame_clk) begin
		if (reset) begin
			model <= model_reset();
		end else begin
			assert (sprite === model.sprite) else begin
				$display("Error: sprite expected %h, got %h", model.sprite, sprite);
				mismatches++;
			end
			assert (stats === model.stats) else begin
				$display("Error: stats expected %h, got %h", model.stats, stats);
				mismatches++;
			end
			model <= model_step(model, eaten, hurt, key);
		end
	end

	// ------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int raise_level(input int v);
		return (v >= 15) ? 15 : v + 1;
	endfunction

	function automatic int lower_level(input int v);
		return (v <= 0) ? 0 : v - 1;
	endfunction

	// first idle frame after a check with no zero stat
	function automatic sprite_t first_idle_sprite(input pet_stats_t s);
		if (int'(s.health) >= CONTENT_LEVEL && int'(s.fullness) >= CONTENT_LEVEL
			&& int'(s.affection) >= CONTENT_LEVEL)
			return SPR_HAPPY_BASE + 8'd1;
		return SPR_SAD_BASE + 8'd1;
	endfunction

	task automatic check_value(input string name, input logic [11:0] exp, input logic [11:0] act);
		assert (exp === act) else begin
			$display("Error: %s expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_stats(input int h, input int f, input int a);
		check_value("stats.health", 12'(h), 12'(stats.health));
		check_value("stats.fullness", 12'(f), 12'(stats.fullness));
		check_value("stats.affection", 12'(a), 12'(stats.affection));
	endtask

	// polls on falling edges and returns how many frames it took
	task automatic wait_for_sprite(input sprite_t want, output int frames);
		int n;
		n = 0;
		while (sprite !== want && n < WAIT_LIMIT) begin
			@(negedge frame_clk);
			n++;
		end
		if (sprite !== want) begin
			$display("sprite never reached %h within %0d frames", want, WAIT_LIMIT);
			errors++;
		end
		frames = n;
	endtask

	// single frame inputs
	task automatic pulse_eaten();
		eaten = 1'b1;
		@(negedge frame_clk);
		eaten = 1'b0;
	endtask

	task automatic pulse_hurt();
		hurt = 1'b1;
		@(negedge frame_clk);
		hurt = 1'b0;
	endtask

	task automatic press_key(input key_t k);
		key = k;
		@(negedge frame_clk);
		key = '0;
	endtask

	task automatic report_test(input string name);
		int now;
		now = errors + mismatches;
		tests_run++;
		if (now == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, now - err_mark);
		end
		err_mark = now;
	endtask

	// ------------------------------
	// directed tests and then the random run
	initial begin
		int         frames;
		int         tries;
		logic       done;
		pet_stats_t snap;
		reset        = 1'b1;
		eaten        = 1'b0;
		hurt         = 1'b0;
		key          = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		err_mark     = 0;
		rng          = 32'h51ae;
		repeat (8) @(negedge frame_clk);
		reset = 1'b0;

		// reset values then a1..a8 one dwell apart
		check_value("sprite", 12'(SPR_NEUTRAL), 12'(sprite));
		check_stats(START_LEVEL, START_LEVEL, START_LEVEL);
		wait_for_sprite(SPR_HAPPY_BASE + 8'd1, frames);
		for (int p = 2; p <= 8; p++) begin
			wait_for_sprite(sprite_t'(int'(SPR_HAPPY_BASE) + p), frames);
			check_value("phase dwell", 12'(DWELL), 12'(frames));
		end
		report_test("reset and happy idle");

		// phase 8 took one off health and fullness
		check_stats(4, 4, 5);
		wait_for_sprite(SPR_SAD_BASE + 8'd1, frames);
		for (int p = 2; p <= 8; p++) begin
			wait_for_sprite(sprite_t'(int'(SPR_SAD_BASE) + p), frames);
			check_value("phase dwell", 12'(DWELL), 12'(frames));
		end
		check_stats(3, 3, 5);
		report_test("decay and sad idle");

		// feed until fullness passes the limit
		wait_for_sprite(SPR_SAD_BASE + 8'd1, frames);
		done  = 1'b0;
		tries = 0;
		while (!done && tries < 12) begin
			snap = stats;
			pulse_eaten();
			wait_for_sprite(SPR_NEUTRAL, frames);
			if (int'(snap.fullness) <= FULL_LIMIT) begin
				wait_for_sprite(SPR_FED, frames);
				check_stats(raise_level(int'(snap.health)), raise_level(int'(snap.fullness)),
					int'(snap.affection));
			end else begin
				wait_for_sprite(SPR_SAD, frames);
				check_stats(lower_level(int'(snap.health)), int'(snap.fullness),
					int'(snap.affection));
				done = 1'b1;
			end
			tries++;
		end
		if (!done) begin
			$display("feeding never pushed fullness past the limit");
			errors++;
		end
		report_test("feeding to upset");

		// pet with eaten and hurt inside the reward
		wait_for_sprite(first_idle_sprite(stats), frames);
		snap = stats;
		press_key(PET_KEY);
		wait_for_sprite(SPR_NEUTRAL, frames);
		wait_for_sprite(SPR_PETTED, frames);
		check_stats(raise_level(int'(snap.health)), int'(snap.fullness),
			raise_level(int'(snap.affection)));
		pulse_eaten();
		pulse_hurt();
		wait_for_sprite(SPR_NEUTRAL, frames);
		check_stats(raise_level(int'(snap.health)), int'(snap.fullness),
			raise_level(int'(snap.affection)));
		// a single check frame sits between the reward and idle
		wait_for_sprite(first_idle_sprite(stats), frames);
		check_value("check to idle frames", 12'd1, 12'(frames));
		check_stats(raise_level(int'(snap.health)), int'(snap.fullness),
			raise_level(int'(snap.affection)));
		report_test("petting");

		// hurt down to zero health
		tries = 0;
		while (stats.health != 4'd0 && tries < 30) begin
			pulse_hurt();
			@(negedge frame_clk);
			tries++;
		end
		check_value("stats.health", 12'd0, 12'(stats.health));
		wait_for_sprite(SPR_NEUTRAL, frames);
		wait_for_sprite(SPR_SAD, frames);
		// dead ignores every other key
		for (int i = 0; i < 12; i++) begin
			key = (i % 3 == 0) ? PET_KEY : key_t'(8'h40 + i);
			@(negedge frame_clk);
			check_value("sprite", 12'(SPR_SAD), 12'(sprite));
		end
		key = '0;
		press_key(START_KEY);
		wait_for_sprite(SPR_HAPPY_BASE + 8'd1, frames);
		check_stats(START_LEVEL, START_LEVEL, START_LEVEL);
		report_test("death and restart");

		// rare events while the model compares every frame
		for (int i = 0; i < 3000; i++) begin
			rng   = lcg_next(rng);
			eaten = (rng[19:16] == 4'd0);
			hurt  = (rng[23:20] == 4'd0);
			case (rng[28:24])
				5'd0:    key = PET_KEY;
				5'd1:    key = START_KEY;
				5'd2:    key = rng[15:8];
				default: key = '0;
			endcase
			@(negedge frame_clk);
		end
		eaten = 1'b0;
		hurt  = 1'b0;
		key   = '0;
		@(negedge frame_clk);
		report_test("random run");

		$display("%0d tests, %0d failed, %0d directed errors, %0d model mismatches",
			tests_run, tests_failed, errors, mismatches);
		if (errors == 0 && mismatches == 0 && tests_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* pet_game.f */
+incdir+verif
design/pet_pkg.sv
design/frame_timer.sv
design/stat_keeper.sv
design/pet_fsm.sv
design/sprite_select.sv
design/pet_game.sv
verif/pet_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pet game testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f pet_game.f \
	--top-module pet_game_tb -Mdir obj_dir > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vpet_game_tb > sim.log 2>&1 \
	|| { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
